/* bench/gmii_tx_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_monitor
(
   input  logic       clk_i,
   input  logic [7:0] txd_i,
   input  logic       tx_en_i,
   input  logic       tx_er_i,
   output logic       error_o
);

`include "crc32_step.svh"

   typedef struct packed
   {
      logic [15:0] len;
      logic        pad_en;
      logic        fcs_en;
      logic [7:0]  ifg;
      logic        exact_gap;               // Gap before this frame is fixed
   } frame_info_t;

   logic [7:0]  payload_q [$];
   frame_info_t info_q [$];
   logic [7:0]  wire_q [$];                 // Bytes still due on the wire
   int          frames_seen;
   int          gap_cnt;
   int          byte_idx;
   logic        in_frame;
   logic        have_prev;
   logic [7:0]  prev_ifg;

   initial
   begin
      error_o = 1'b0;
      frames_seen = 0;
      gap_cnt = 0;
      byte_idx = 0;
      in_frame = 1'b0;
      have_prev = 1'b0;
      prev_ifg = 8'h00;
   end

   task automatic expect_byte(input logic [7:0] data);
      payload_q.push_back(data);
   endtask

   task automatic expect_frame(input int len, input logic pad_en, input logic fcs_en,
                               input logic [7:0] ifg, input logic exact_gap);
      frame_info_t f;
      f.len = 16'(len);
      f.pad_en = pad_en;
      f.fcs_en = fcs_en;
      f.ifg = ifg;
      f.exact_gap = exact_gap;
      info_q.push_back(f);
   endtask

   function automatic int pending_items();
      return payload_q.size() + info_q.size() + wire_q.size();
   endfunction

   task automatic mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      error_o = 1'b1;
   endtask

   task automatic protocol_fault(input string msg);
      $display("At %0t: %s", $time, msg);
      error_o = 1'b1;
   endtask

   // Preamble, SFD, payload, zero pad, then complemented CRC low byte first
   task automatic build_wire(input frame_info_t f);
      logic [31:0] crc;
      logic [31:0] fcs;
      logic [7:0]  b;
      int          body;
      crc = eth_pkg::CRC_RESIDUE_INIT;
      body = int'(f.len);
      if (f.pad_en && body < eth_pkg::MIN_PAYLOAD)
         body = eth_pkg::MIN_PAYLOAD;
      repeat (eth_pkg::PREAMBLE_LEN) wire_q.push_back(eth_pkg::PREAMBLE_BYTE);
      wire_q.push_back(eth_pkg::SFD_BYTE);
      for (int i = 0; i < body; i++)
      begin
         b = 8'h00;
         if (i < int'(f.len))
            b = payload_q.pop_front();
         crc = crc32_step(crc, b);
         wire_q.push_back(b);
      end
      fcs = ~crc;
      if (f.fcs_en)
         for (int i = 0; i < 4; i++)
            wire_q.push_back(fcs[8*i +: 8]);
   endtask

   task automatic check_cycle();
      frame_info_t f;
      logic [7:0]  exp_b;
      assert (tx_er_i == 1'b0)
      else mismatch("gmii_tx_er_o is high");
      if (tx_en_i && !in_frame)
      begin
         assert (info_q.size() != 0)
         else protocol_fault("A frame started on the wire but none was queued");
         if (error_o)
            return;
         f = info_q.pop_front();
         if (have_prev && f.exact_gap)
         begin
            assert (gap_cnt == int'(prev_ifg))
            else mismatch($sformatf("gap of %0d cycles, expected %0d", gap_cnt, prev_ifg));
         end
         else if (have_prev)
         begin
            assert (gap_cnt >= int'(prev_ifg))
            else mismatch($sformatf("gap of %0d cycles, minimum %0d", gap_cnt, prev_ifg));
         end
         assert (payload_q.size() >= int'(f.len))
         else protocol_fault("Fewer payload bytes queued than the frame length");
         if (error_o)
            return;
         build_wire(f);
         prev_ifg = f.ifg;
         in_frame = 1'b1;
         byte_idx = 0;
      end
      if (tx_en_i)
      begin
         assert (wire_q.size() != 0)
         else mismatch($sformatf("frame %0d runs past %0d bytes", frames_seen, byte_idx));
         if (error_o)
            return;
         exp_b = wire_q.pop_front();
         assert (txd_i == exp_b)
         else mismatch($sformatf("frame %0d byte %0d is %h, expected %h",
                                 frames_seen, byte_idx, txd_i, exp_b));
         byte_idx++;
      end
      else if (in_frame)
      begin
         assert (wire_q.size() == 0)
         else mismatch($sformatf("frame %0d ended %0d bytes early", frames_seen, wire_q.size()));
         in_frame = 1'b0;
         have_prev = 1'b1;
         gap_cnt = 1;                        // This cycle is already idle
         frames_seen++;
      end
      else if (have_prev)
         gap_cnt++;
   endtask

   // Registered outputs are settled at the falling edge
   always @(negedge clk_i)
   begin
      if (!error_o)
         check_cycle();
   end

endmodule

`default_nettype wire

/* bench/gmii_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_tb;

   typedef struct packed
   {
      logic [15:0] len;
      logic [2:0]  ctrl;                    // {fcs, pad, tx}
      logic [7:0]  ifg;
      logic        hold;                    // Random idle cycles on in_valid
      logic [3:0]  nframes;
      logic        exact_gap;
      logic        expect_full;
      logic [15:0] exp_count;               // ADDR_FRAMES after the row
   } test_row_t;

   localparam int NUM_ROWS = 11;

   // Columns: len, ctrl, ifg, hold, frames, exact gap, expect full, frame count
   test_row_t rows [NUM_ROWS] = '{
      '{16'd64,  3'b111, 8'd12, 1'b0, 4'd1, 1'b0, 1'b0, 16'd1},
      '{16'd1,   3'b111, 8'd12, 1'b1, 4'd1, 1'b0, 1'b0, 16'd2},
      '{16'd59,  3'b111, 8'd12, 1'b1, 4'd1, 1'b0, 1'b0, 16'd3},
      '{16'd1,   3'b101, 8'd12, 1'b0, 4'd1, 1'b0, 1'b0, 16'd4},
      '{16'd59,  3'b101, 8'd12, 1'b1, 4'd1, 1'b0, 1'b0, 16'd5},
      '{16'd45,  3'b011, 8'd12, 1'b0, 4'd2, 1'b0, 1'b0, 16'd7},
      '{16'd30,  3'b001, 8'd12, 1'b1, 4'd2, 1'b0, 1'b0, 16'd9},
      '{16'd64,  3'b111, 8'd12, 1'b0, 4'd3, 1'b1, 1'b0, 16'd12},
      '{16'd64,  3'b111, 8'd20, 1'b0, 4'd3, 1'b1, 1'b0, 16'd15},
      '{16'd120, 3'b111, 8'd12, 1'b0, 4'd2, 1'b0, 1'b1, 16'd17},
      '{16'd70,  3'b110, 8'd16, 1'b1, 4'd1, 1'b0, 1'b0, 16'd18}
   };

   logic                GMII_GTX_CLK_int;
   logic                reset_i;
   eth_pkg::byte_beat_t in_beat;
   logic                in_valid;
   logic                in_ready;
   cfg_pkg::reg_cmd_t   cmd;
   logic [15:0]         rdata;
   logic [7:0]          gmii_txd;
   logic                gmii_tx_en;
   logic                gmii_tx_er;
   logic                mon_error;
   logic                saw_full;           // in_ready low while offering a byte

   gmii_tx_top #(.FIFO_DEPTH(128), .RESET_IFG(12)) uut
   (
      .clk_i        (GMII_GTX_CLK_int),
      .reset_i      (reset_i),
      .in_beat_i    (in_beat),
      .in_valid_i   (in_valid),
      .in_ready_o   (in_ready),
      .cmd_i        (cmd),
      .rdata_o      (rdata),
      .gmii_txd_o   (gmii_txd),
      .gmii_tx_en_o (gmii_tx_en),
      .gmii_tx_er_o (gmii_tx_er)
   );

   gmii_tx_monitor mon
   (
      .clk_i   (GMII_GTX_CLK_int),
      .txd_i   (gmii_txd),
      .tx_en_i (gmii_tx_en),
      .tx_er_i (gmii_tx_er),
      .error_o (mon_error)
   );

   initial
   begin
      GMII_GTX_CLK_int = 1'b0;
      forever #2 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped on the first error");
   endtask

   task automatic value_mismatch(input string msg);
      abort_run($sformatf("MISMATCH at %0t: %s", $time, msg));
   endtask

   task automatic reg_write(input cfg_pkg::reg_addr_t addr, input logic [15:0] data);
      @(posedge GMII_GTX_CLK_int);
      cmd <= '{op: cfg_pkg::REG_WRITE, addr: addr, wdata: data};
      @(posedge GMII_GTX_CLK_int);
      cmd <= '{op: cfg_pkg::REG_NOP, addr: cfg_pkg::ADDR_CTRL, wdata: 16'h0000};
   endtask

   task automatic reg_read(input cfg_pkg::reg_addr_t addr, output logic [15:0] data);
      @(posedge GMII_GTX_CLK_int);
      cmd <= '{op: cfg_pkg::REG_READ, addr: addr, wdata: 16'h0000};
      @(posedge GMII_GTX_CLK_int);
      cmd <= '{op: cfg_pkg::REG_NOP, addr: cfg_pkg::ADDR_CTRL, wdata: 16'h0000};
      @(negedge GMII_GTX_CLK_int);
      data = rdata;
   endtask

   // Returns at a falling edge with the byte about to be taken
   task automatic push_beat(input logic [7:0] data, input logic last, input logic hold);
      int idle;
      idle = hold ? int'($urandom_range(2, 0)) : 0;
      repeat (idle)
      begin
         @(posedge GMII_GTX_CLK_int);
         in_valid <= 1'b0;
      end
      @(posedge GMII_GTX_CLK_int);
      in_beat <= '{data: data, last: last};
      in_valid <= 1'b1;
      @(negedge GMII_GTX_CLK_int);
      while (!in_ready)
      begin
         saw_full = 1'b1;
         @(negedge GMII_GTX_CLK_int);
      end
   endtask

   task automatic send_frame(input test_row_t row, input logic exact);
      logic [7:0] b;
      mon.expect_frame(int'(row.len), row.ctrl[1], row.ctrl[2], row.ifg, exact);
      for (int i = 0; i < int'(row.len); i++)
      begin
         b = 8'($urandom);
         mon.expect_byte(b);
         push_beat(b, i == int'(row.len) - 1, row.hold);
      end
   endtask

   task automatic run_row(input test_row_t row, input int idx);
      logic [15:0] val;
      saw_full = 1'b0;
      reg_write(cfg_pkg::ADDR_IFG, {8'h00, row.ifg});
      reg_write(cfg_pkg::ADDR_CTRL, {13'h0000, row.ctrl});
      for (int f = 0; f < int'(row.nframes); f++)
         send_frame(row, (f > 0) && row.exact_gap);
      @(posedge GMII_GTX_CLK_int);
      in_valid <= 1'b0;
      if (!row.ctrl[0])
      begin
         // Frame sits complete in the FIFO while disabled
         repeat (100)
         begin
            @(negedge GMII_GTX_CLK_int);
            assert (!gmii_tx_en)
            else abort_run("A frame started on the wire while tx_enable was clear");
         end
         reg_write(cfg_pkg::ADDR_CTRL, {13'h0000, row.ctrl | 3'b001});
      end
      while (mon.frames_seen < int'(row.exp_count))
         @(negedge GMII_GTX_CLK_int);
      if (row.expect_full)
      begin
         assert (saw_full)
         else abort_run("in_ready_o never went low although the FIFO had to fill");
      end
      reg_read(cfg_pkg::ADDR_CTRL, val);
      assert (val == {13'h0000, row.ctrl | 3'b001})
      else value_mismatch($sformatf("row %0d ADDR_CTRL read %h", idx, val));
      reg_read(cfg_pkg::ADDR_IFG, val);
      assert (val == {8'h00, row.ifg})
      else value_mismatch($sformatf("row %0d ADDR_IFG read %h", idx, val));
      reg_read(cfg_pkg::ADDR_FRAMES, val);
      assert (val == row.exp_count && int'(val) == mon.frames_seen)
      else value_mismatch($sformatf("row %0d ADDR_FRAMES read %0d, expected %0d, seen %0d",
                                    idx, val, row.exp_count, mon.frames_seen));
      $display("Row %0d done, %0d frames on the wire", idx, mon.frames_seen);
   endtask

   // Longest wire time plus gap plus a slow input side, per frame, doubled
   function automatic int run_budget();
      int total;
      int body;
      total = 0;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         body = int'(rows[r].len);
         if (body < eth_pkg::MIN_PAYLOAD)
            body = eth_pkg::MIN_PAYLOAD;
         total += int'(rows[r].nframes) * (eth_pkg::PREAMBLE_LEN + 1 + body + 4
                  + int'(rows[r].ifg) + 3 * int'(rows[r].len));
         total += 150;                       // Register traffic and the disabled wait
      end
      return 2 * total;
   endfunction

   initial
   begin
      int limit;
      limit = run_budget();
      repeat (limit) @(posedge GMII_GTX_CLK_int);
      abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles", limit));
   end

   initial
   begin
      @(posedge mon_error);
      abort_run("The frame check on the GMII outputs failed");
   end

   initial
   begin
      int seed_ret;
      reset_i <= 1'b1;
      in_beat <= '0;
      in_valid <= 1'b0;
      cmd <= '{op: cfg_pkg::REG_NOP, addr: cfg_pkg::ADDR_CTRL, wdata: 16'h0000};
      saw_full = 1'b0;
      seed_ret = $urandom(32'h9c6c);
      repeat (3) @(posedge GMII_GTX_CLK_int);
      reset_i <= 1'b0;
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(rows[r], r);
      repeat (10) @(posedge GMII_GTX_CLK_int);
      if (mon.pending_items() == 0 && !mon_error)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
         abort_run("Queued frames or bytes never appeared on the GMII outputs");
   end

endmodule

`default_nettype wire

/* include/crc32_step.svh */
// Ethernet CRC-32 in reflected form, LSB of each byte first
function automatic logic [31:0] crc32_step
(
   input logic [31:0] crc_in,
   input logic [7:0]  data
);
   logic [31:0] crc;

   crc = crc_in ^ {24'h000000, data};
   for (int i = 0; i < 8; i++)
   begin
      if (crc[0])
         crc = (crc >> 1) ^ 32'hEDB8_8320;
      else
         crc = crc >> 1;
   end
   return crc;
endfunction

// Complemented state is the FCS, low byte on the wire first
function automatic logic [31:0] crc32_final
(
   input logic [31:0] crc_in
);
   return crc_in ^ eth_pkg::CRC_RESIDUE_INIT;
endfunction

/* run_sim.sh */
#!/bin/sh
# Build and run the GMII transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module gmii_tx_tb -f sim.f -o gmii_tx_sim > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/gmii_tx_sim > sim.log 2>&1
status=$?
cat sim.log

# The log decides the result
if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
exit 0

/* sim.f */
+incdir+include
verilog/eth_pkg.sv
verilog/cfg_pkg.sv
verilog/tx_cfg_regs.sv
verilog/tx_frame_fifo.sv
verilog/gmii_tx_mac.sv
verilog/gmii_tx_top.sv
bench/gmii_tx_monitor.sv
bench/gmii_tx_tb.sv

/* verilog/cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

   typedef enum logic [1:0] {REG_NOP, REG_WRITE, REG_READ} reg_op_t;

   typedef logic [3:0] reg_addr_t;
   localparam reg_addr_t ADDR_CTRL = 4'd0;
   localparam reg_addr_t ADDR_IFG = 4'd1;
   localparam reg_addr_t ADDR_FRAMES = 4'd2;   // Read only

   typedef struct packed
   {
      reg_op_t     op;
      reg_addr_t   addr;
      logic [15:0] wdata;
   } reg_cmd_t;

   typedef struct packed
   {
      logic       tx_enable;
      logic       pad_enable;
      logic       fcs_enable;
      logic [7:0] ifg_len;                  // Idle cycles after each frame
   } tx_cfg_t;

endpackage

`default_nettype wire

/* verilog/eth_pkg.sv */
`default_nettype none

package eth_pkg;

   // Wire framing
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE = 8'hD5;
   localparam int PREAMBLE_LEN = 7;
   localparam int MIN_PAYLOAD = 60;         // Bytes before the FCS

   // Seed and final XOR of the CRC-32
   localparam logic [31:0] CRC_RESIDUE_INIT = 32'hFFFF_FFFF;

   // One byte of a frame on the stream side
   typedef struct packed
   {
      logic [7:0] data;
      logic       last;                     // Final payload byte
   } byte_beat_t;

   typedef enum logic [2:0]
   {
      IDLE,
      PREAMBLE,
      SFD,
      PAYLOAD,
      PAD,
      FCS,
      GAP
   } mac_state_t;

endpackage

`default_nettype wire

/* verilog/gmii_tx_mac.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_mac
(
   input  logic                clk_i,
   input  logic                reset_i,
   input  cfg_pkg::tx_cfg_t    cfg_i,
   input  eth_pkg::byte_beat_t beat_i,
   input  logic                valid_i,
   output logic                ready_o,
   input  logic                frame_avail_i,
   output logic                frame_done_o,
   output logic [7:0]          gmii_txd_o,
   output logic                gmii_tx_en_o,
   output logic                gmii_tx_er_o
);

`include "crc32_step.svh"

   eth_pkg::mac_state_t state;
   eth_pkg::mac_state_t state_d;
   eth_pkg::mac_state_t end_state;
   cfg_pkg::tx_cfg_t    cfg_q;                 // Held for the whole frame
   logic [7:0]          cnt;
   logic [31:0]         crc_q;
   logic [31:0]         fcs_word;
   logic [7:0]          txd_int;
   logic                tx_en_int;
   logic                start;
   logic                launch;
   logic                take;
   logic                pad_needed;
   logic                frame_last;

   assign start = frame_avail_i && cfg_i.tx_enable;
   assign take = valid_i && ready_o;
   assign pad_needed = cfg_q.pad_enable && (cnt < 8'(eth_pkg::MIN_PAYLOAD - 1));
   assign end_state = (cfg_q.ifg_len == 8'd0) ? eth_pkg::IDLE : eth_pkg::GAP;
   assign launch = (state_d == eth_pkg::PREAMBLE) && (state != eth_pkg::PREAMBLE);
   assign fcs_word = crc32_final(crc_q);

   always_comb
   begin
      state_d = state;
      case (state)
         eth_pkg::IDLE:
            if (start)
               state_d = eth_pkg::PREAMBLE;
         eth_pkg::PREAMBLE:
            if (cnt == 8'(eth_pkg::PREAMBLE_LEN - 1))
               state_d = eth_pkg::SFD;
         eth_pkg::SFD: state_d = eth_pkg::PAYLOAD;
         eth_pkg::PAYLOAD:
            if (take && beat_i.last)
            begin
               if (pad_needed)
                  state_d = eth_pkg::PAD;
               else if (cfg_q.fcs_enable)
                  state_d = eth_pkg::FCS;
               else
                  state_d = end_state;
            end
         eth_pkg::PAD:
            if (cnt == 8'(eth_pkg::MIN_PAYLOAD - 1))
               state_d = cfg_q.fcs_enable ? eth_pkg::FCS : end_state;
         eth_pkg::FCS:
            if (cnt == 8'd3)
               state_d = end_state;
         eth_pkg::GAP:
            // Next frame may follow straight after the gap
            if (cnt == cfg_q.ifg_len - 8'd1)
               state_d = start ? eth_pkg::PREAMBLE : eth_pkg::IDLE;
         default: state_d = eth_pkg::IDLE;
      endcase
   end

   // Byte for the current state
   always_comb
   begin
      txd_int = 8'h00;
      tx_en_int = 1'b1;
      ready_o = 1'b0;
      case (state)
         eth_pkg::PREAMBLE: txd_int = eth_pkg::PREAMBLE_BYTE;
         eth_pkg::SFD:      txd_int = eth_pkg::SFD_BYTE;
         eth_pkg::PAYLOAD:
         begin
            txd_int = beat_i.data;
            ready_o = 1'b1;
         end
         eth_pkg::PAD:      txd_int = 8'h00;
         eth_pkg::FCS:      txd_int = fcs_word[{cnt[1:0], 3'b000} +: 8];
         default:           tx_en_int = 1'b0;
      endcase
      frame_last = tx_en_int && (state_d == eth_pkg::IDLE || state_d == eth_pkg::GAP);
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state <= eth_pkg::IDLE;
         cnt <= 8'h00;
         cfg_q <= '0;
         crc_q <= eth_pkg::CRC_RESIDUE_INIT;
      end
      else
      begin
         state <= state_d;
         // Payload count runs on into PAD
         if (state_d != state && state_d != eth_pkg::PAD)
            cnt <= 8'h00;
         else if (cnt != 8'hFF)
            cnt <= cnt + 8'd1;
         if (launch)
         begin
            cfg_q <= cfg_i;
            crc_q <= eth_pkg::CRC_RESIDUE_INIT;
         end
         else if (state == eth_pkg::PAYLOAD && take)
            crc_q <= crc32_step(crc_q, beat_i.data);
         else if (state == eth_pkg::PAD)
            crc_q <= crc32_step(crc_q, 8'h00);
      end
   end

   // GMII output register
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         gmii_txd_o <= 8'h00;
         gmii_tx_en_o <= 1'b0;
         gmii_tx_er_o <= 1'b0;
         frame_done_o <= 1'b0;
      end
      else
      begin
         gmii_txd_o <= txd_int;
         gmii_tx_en_o <= tx_en_int;
         gmii_tx_er_o <= 1'b0;         // No error source
         frame_done_o <= frame_last;
      end
   end

   // Whole frame is stored before launch, so payload never starves
   a_payload_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      (state == eth_pkg::PAYLOAD) |-> valid_i);

endmodule

`default_nettype wire

/* verilog/gmii_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_top
#(
   parameter int FIFO_DEPTH = 2048,
   parameter int RESET_IFG = 12
)
(
   input  logic                clk_i,
   input  logic                reset_i,
   input  eth_pkg::byte_beat_t in_beat_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   input  cfg_pkg::reg_cmd_t   cmd_i,
   output logic [15:0]         rdata_o,
   output logic [7:0]          gmii_txd_o,
   output logic                gmii_tx_en_o,
   output logic                gmii_tx_er_o
);

   eth_pkg::byte_beat_t fifo_beat;
   logic                fifo_valid;
   logic                mac_ready;
   logic                frame_avail;
   cfg_pkg::tx_cfg_t    cfg;
   logic                frame_done;

   tx_frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .in_beat_i     (in_beat_i),
      .in_valid_i    (in_valid_i),
      .in_ready_o    (in_ready_o),
      .out_beat_o    (fifo_beat),
      .out_valid_o   (fifo_valid),
      .out_ready_i   (mac_ready),
      .frame_avail_o (frame_avail)
   );

   gmii_tx_mac u_mac
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cfg_i         (cfg),
      .beat_i        (fifo_beat),
      .valid_i       (fifo_valid),
      .ready_o       (mac_ready),
      .frame_avail_i (frame_avail),
      .frame_done_o  (frame_done),
      .gmii_txd_o    (gmii_txd_o),
      .gmii_tx_en_o  (gmii_tx_en_o),
      .gmii_tx_er_o  (gmii_tx_er_o)
   );

   tx_cfg_regs #(.RESET_IFG(RESET_IFG)) u_regs
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cmd_i         (cmd_i),
      .frame_done_i  (frame_done),
      .cfg_o         (cfg),
      .rdata_o       (rdata_o)
   );

endmodule

`default_nettype wire

/* verilog/tx_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_cfg_regs
#(
   parameter int RESET_IFG = 12
)
(
   input  logic             clk_i,
   input  logic             reset_i,
   input  cfg_pkg::reg_cmd_t cmd_i,
   input  logic             frame_done_i,
   output cfg_pkg::tx_cfg_t  cfg_o,
   output logic [15:0]      rdata_o
);

   cfg_pkg::tx_cfg_t cfg_q;
   logic [15:0]      frame_cnt;
   logic [15:0]      read_val;

   assign cfg_o = cfg_q;

   // Read mux
   always_comb
   begin
      case (cmd_i.addr)
         cfg_pkg::ADDR_CTRL:
            read_val = {13'h0000, cfg_q.fcs_enable, cfg_q.pad_enable, cfg_q.tx_enable};
         cfg_pkg::ADDR_IFG:    read_val = {8'h00, cfg_q.ifg_len};
         cfg_pkg::ADDR_FRAMES: read_val = frame_cnt;
         default:              read_val = 16'h0000;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         cfg_q.tx_enable <= 1'b1;
         cfg_q.pad_enable <= 1'b1;
         cfg_q.fcs_enable <= 1'b1;
         cfg_q.ifg_len <= 8'(RESET_IFG);
         frame_cnt <= 16'h0000;
         rdata_o <= 16'h0000;
      end
      else
      begin
         case (cmd_i.op)
            cfg_pkg::REG_WRITE:
            begin
               if (cmd_i.addr == cfg_pkg::ADDR_CTRL)
               begin
                  cfg_q.tx_enable <= cmd_i.wdata[0];
                  cfg_q.pad_enable <= cmd_i.wdata[1];
                  cfg_q.fcs_enable <= cmd_i.wdata[2];
               end
               else if (cmd_i.addr == cfg_pkg::ADDR_IFG)
                  cfg_q.ifg_len <= cmd_i.wdata[7:0];
            end
            cfg_pkg::REG_READ: rdata_o <= read_val;   // Held until next read
            default: ;
         endcase
         if (frame_done_i)
            frame_cnt <= frame_cnt + 16'd1;           // Wraps
      end
   end

endmodule

`default_nettype wire

/* verilog/tx_frame_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_frame_fifo
#(
   parameter int FIFO_DEPTH = 2048
)
(
   input  logic                clk_i,
   input  logic                reset_i,
   input  eth_pkg::byte_beat_t in_beat_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output eth_pkg::byte_beat_t out_beat_o,
   output logic                out_valid_o,
   input  logic                out_ready_i,
   output logic                frame_avail_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   eth_pkg::byte_beat_t mem [FIFO_DEPTH];
   logic [AW:0]         wr_ptr;
   logic [AW:0]         rd_ptr;
   logic [AW:0]         used;
   logic [AW:0]         frame_cnt;             // Frames fully stored
   logic                wr_en;
   logic                rd_en;

   // Extra pointer bit tells full from empty
   assign used = wr_ptr - rd_ptr;
   assign in_ready_o = !used[AW];
   assign out_valid_o = (used != '0);
   assign out_beat_o = mem[rd_ptr[AW-1:0]];
   assign wr_en = in_valid_i && in_ready_o;
   assign rd_en = out_valid_o && out_ready_i;
   assign frame_avail_o = (frame_cnt != '0);

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
         mem[wr_ptr[AW-1:0]] <= in_beat_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         frame_cnt <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         // A frame counts once its last byte is in, until that byte leaves
         case ({wr_en && in_beat_i.last, rd_en && out_beat_o.last})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;
            2'b01:   frame_cnt <= frame_cnt - 1'b1;
            default: ;
         endcase
      end
   end

   // Pointer distance never passes the depth
   a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
      int'(used) <= FIFO_DEPTH);

   // A last byte only leaves when its frame was counted
   a_frame_cnt_floor: assert property (@(posedge clk_i) disable iff (reset_i)
      (rd_en && out_beat_o.last) |-> (frame_cnt != '0));

endmodule

`default_nettype wire
